// File: biss_consts.svh
`ifndef BISS_CONSTS_SVH
`define BISS_CONSTS_SVH

//==========================================================================
// MA clock timing
//==========================================================================

// clk cycles per MA half period
`define BISS_MA_HALF 4

//==========================================================================
// Frame layout
//==========================================================================

`define BISS_FRAME_BITS 32
`define BISS_POS_BITS 24
`define BISS_CRC_BITS 6
// Position plus error and warning
`define BISS_CRC_DATA_BITS 26

// Timeouts in MA periods
`define BISS_ACK_LIMIT 40
`define BISS_IDLE_LIMIT 64

// Result buffer and consumer credits
`define BISS_FIFO_DEPTH 4
`define BISS_CREDIT_INIT 2

`endif

// File: biss_pkg.sv
`include "biss_consts.svh"

package biss_pkg;

	// Single-cycle-data word, seen either as the shifted bit vector
	// or split into its fields, most significant first
	typedef union packed {
		logic [`BISS_FRAME_BITS-1:0] raw;
		struct packed {
			logic [`BISS_POS_BITS-1:0] position;
			// Both flags are active low on the line
			logic error_n;
			logic warning_n;
			// Slave sends the CRC inverted
			logic [`BISS_CRC_BITS-1:0] crc_n;
		} fld;
	} scd_word_t;

endpackage

// File: biss_frame_rx.sv
`timescale 1ns/10ps
`include "biss_consts.svh"

module biss_frame_rx (
	input  logic                clk,
	input  logic                BISS_start,
	input  logic                run,
	input  logic                slo,
	input  logic                fifo_room,
	output logic                ma,
	output logic                no_ack,
	output logic                bit_valid,
	output logic                bit_data,
	output logic                frame_done,
	output biss_pkg::scd_word_t frame_word
);

	localparam int PH_W  = $clog2(2 * `BISS_MA_HALF);
	localparam int PER_W = $clog2(`BISS_IDLE_LIMIT + 1);
	localparam int BIT_W = $clog2(`BISS_FRAME_BITS);

	localparam logic [PH_W-1:0]  PH_HIGH  = PH_W'(`BISS_MA_HALF);
	localparam logic [PH_W-1:0]  PH_LAST  = PH_W'(2 * `BISS_MA_HALF - 1);
	localparam logic [PER_W-1:0] ACK_END  = PER_W'(`BISS_ACK_LIMIT - 1);
	localparam logic [PER_W-1:0] IDLE_END = PER_W'(`BISS_IDLE_LIMIT - 1);
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`BISS_FRAME_BITS - 1);

	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_ACK   = 3'd1;
	localparam logic [2:0] ST_START = 3'd2;
	localparam logic [2:0] ST_CDS   = 3'd3;
	localparam logic [2:0] ST_DATA  = 3'd4;
	localparam logic [2:0] ST_END   = 3'd5;
	localparam logic [2:0] ST_NOACK = 3'd6;

	logic [2:0]       filt_q;
	logic             slo_filt;
	logic [2:0]       state;
	logic [PH_W-1:0]  phase;
	logic [PER_W-1:0] period_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic             last_q;
	logic             start_frame;
	logic             sample;
	logic             toggling;

	//==========================================================================
	// SLO majority filter with two cycles of latency
	//==========================================================================
	always_ff @(posedge clk or negedge BISS_start) begin
		if (!BISS_start)
			filt_q <= '1;
		else
			filt_q <= {filt_q[1:0], slo};
	end

	assign slo_filt = (filt_q[0] & filt_q[1]) | (filt_q[0] & filt_q[2]) | (filt_q[1] & filt_q[2]);

	//==========================================================================
	// MA divider
	//==========================================================================
	assign start_frame = (state == ST_IDLE) && run && fifo_room && slo_filt;

	// Phase restarts with each frame so MA begins low
	always_ff @(posedge clk or negedge BISS_start) begin
		if (!BISS_start)
			phase <= '0;
		else if (start_frame || phase == PH_LAST)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	// Slave data is settled by the end of the MA high half
	assign sample   = (phase == PH_LAST);
	assign toggling = (state == ST_ACK) || (state == ST_START) ||
		(state == ST_CDS) || (state == ST_DATA);
	assign ma       = toggling ? (phase >= PH_HIGH) : 1'b1;

	//==========================================================================
	// Frame FSM
	//==========================================================================
	always_ff @(posedge clk or negedge BISS_start) begin
		if (!BISS_start) begin
			state      <= ST_IDLE;
			period_cnt <= '0;
			bit_cnt    <= '0;
			last_q     <= 1'b0;
			no_ack     <= 1'b0;
			bit_valid  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			bit_valid  <= 1'b0;
			frame_done <= bit_valid & last_q;
			if (start_frame) begin
				state      <= ST_ACK;
				period_cnt <= '0;
			end else if (sample) begin
				period_cnt <= period_cnt + 1'b1;
				case (state)
					ST_ACK, ST_START: begin
						if (state == ST_START && slo_filt) begin
							state  <= ST_CDS;
							no_ack <= 1'b0;
						end else if (period_cnt == ACK_END) begin
							// No start bit in time
							state      <= ST_NOACK;
							no_ack     <= 1'b1;
							period_cnt <= '0;
						end else if (state == ST_ACK && !slo_filt) begin
							state <= ST_START;
						end
					end
					ST_CDS: begin
						state   <= ST_DATA;
						bit_cnt <= '0;
					end
					ST_DATA: begin
						bit_valid <= 1'b1;
						last_q    <= (bit_cnt == BIT_LAST);
						bit_cnt   <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_LAST) begin
							state      <= ST_END;
							period_cnt <= '0;
						end
					end
					ST_END: begin
						if (slo_filt || period_cnt == IDLE_END)
							state <= ST_IDLE;
					end
					ST_NOACK: begin
						if (period_cnt == IDLE_END)
							state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// Data shifter filling MSB first
	always_ff @(posedge clk) begin
		if (sample && state == ST_DATA) begin
			bit_data       <= slo_filt;
			frame_word.raw <= {frame_word.raw[`BISS_FRAME_BITS-2:0], slo_filt};
		end
	end

	// MA rests high in idle and starts low when a frame opens
	a_ma_idle: assert property (@(posedge clk) disable iff (!BISS_start)
		(state == ST_IDLE) |=> ((state == ST_IDLE) == ma));

	a_done_single: assert property (@(posedge clk) disable iff (!BISS_start)
		frame_done |=> !frame_done);

endmodule

// File: biss_crc6_check.sv
`timescale 1ns/10ps
`include "biss_consts.svh"

module biss_crc6_check (
	input  logic                clk,
	input  logic                BISS_start,
	input  logic                bit_valid,
	input  logic                bit_data,
	input  logic                frame_done,
	input  biss_pkg::scd_word_t frame_word,
	output logic                chk_valid,
	output biss_pkg::scd_word_t chk_word,
	output logic                chk_crc_ok
);

	localparam int CNT_W = $clog2(`BISS_FRAME_BITS + 1);
	localparam logic [CNT_W-1:0] CNT_CRC  = CNT_W'(`BISS_CRC_DATA_BITS);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`BISS_FRAME_BITS);
	// x^6 + x + 1 without the leading term
	localparam logic [`BISS_CRC_BITS-1:0] POLY = 6'b000011;

	logic [CNT_W-1:0]          bit_cnt;
	logic [`BISS_CRC_BITS-1:0] crc_q;

	function automatic logic [`BISS_CRC_BITS-1:0] crc6_step(
		input logic [`BISS_CRC_BITS-1:0] crc,
		input logic                      d
	);
		logic fb;
		fb = crc[`BISS_CRC_BITS-1] ^ d;
		return {crc[`BISS_CRC_BITS-2:0], 1'b0} ^ (fb ? POLY : '0);
	endfunction

	always_ff @(posedge clk or negedge BISS_start) begin
		if (!BISS_start) begin
			bit_cnt   <= '0;
			chk_valid <= 1'b0;
		end else begin
			chk_valid <= frame_done;
			if (frame_done)
				bit_cnt <= '0;
			else if (bit_valid)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// Seed from zero on the first bit of each frame
	always_ff @(posedge clk) begin
		if (bit_valid && bit_cnt < CNT_CRC)
			crc_q <= crc6_step((bit_cnt == '0) ? '0 : crc_q, bit_data);
	end

	always_ff @(posedge clk) begin
		if (frame_done) begin
			chk_word   <= frame_word;
			chk_crc_ok <= (crc_q == ~frame_word.fld.crc_n);
		end
	end

	a_full_frame: assert property (@(posedge clk) disable iff (!BISS_start)
		frame_done |-> (bit_cnt == CNT_FULL));

endmodule

// File: biss_result_fifo.sv
`timescale 1ns/10ps
`include "biss_consts.svh"

module biss_result_fifo (
	input  logic                clk,
	input  logic                BISS_start,
	input  logic                chk_valid,
	input  biss_pkg::scd_word_t chk_word,
	input  logic                chk_crc_ok,
	input  logic                res_credit,
	output logic                fifo_room,
	output logic                res_valid,
	output biss_pkg::scd_word_t res_word,
	output logic                res_crc_ok
);

	localparam int PTR_W = $clog2(`BISS_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`BISS_FIFO_DEPTH + 1);
	localparam int CRD_W = $clog2(`BISS_CREDIT_INIT + 1);
	localparam logic [CNT_W-1:0] DEPTH       = CNT_W'(`BISS_FIFO_DEPTH);
	localparam logic [PTR_W-1:0] PTR_LAST    = PTR_W'(`BISS_FIFO_DEPTH - 1);
	localparam logic [CRD_W-1:0] CREDIT_INIT = CRD_W'(`BISS_CREDIT_INIT);

	biss_pkg::scd_word_t mem_word [`BISS_FIFO_DEPTH];
	logic                mem_ok [`BISS_FIFO_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic [CRD_W-1:0]    credits;
	logic                issue;

	assign fifo_room = (count < DEPTH);
	// One result per cycle while both data and credit exist
	assign issue     = (count != '0) && (credits != '0);

	always_ff @(posedge clk) begin
		if (chk_valid) begin
			mem_word[wr_ptr] <= chk_word;
			mem_ok[wr_ptr]   <= chk_crc_ok;
		end
		if (issue) begin
			res_word   <= mem_word[rd_ptr];
			res_crc_ok <= mem_ok[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge BISS_start) begin
		if (!BISS_start) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			credits   <= CREDIT_INIT;
			res_valid <= 1'b0;
		end else begin
			res_valid <= issue;
			if (chk_valid)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (issue)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			case ({chk_valid, issue})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Credit spent per result, returned per consumer pulse
			case ({res_credit, issue})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!BISS_start)
		chk_valid |-> (count < DEPTH));

	a_credit_max: assert property (@(posedge clk) disable iff (!BISS_start)
		credits <= CREDIT_INIT);

endmodule

// File: biss_master_top.sv
`timescale 1ns/10ps

module biss_master_top (
	input  logic                clk,
	input  logic                BISS_start,
	input  logic                run,
	input  logic                slo,
	input  logic                res_credit,
	output logic                ma,
	output logic                res_valid,
	output biss_pkg::scd_word_t res_word,
	output logic                res_crc_ok,
	output logic                no_ack
);

	logic                bit_valid;
	logic                bit_data;
	logic                frame_done;
	biss_pkg::scd_word_t frame_word;
	logic                chk_valid;
	biss_pkg::scd_word_t chk_word;
	logic                chk_crc_ok;
	logic                fifo_room;

	// Line side
	biss_frame_rx u_frame_rx (
		.clk        (clk),
		.BISS_start (BISS_start),
		.run        (run),
		.slo        (slo),
		.fifo_room  (fifo_room),
		.ma         (ma),
		.no_ack     (no_ack),
		.bit_valid  (bit_valid),
		.bit_data   (bit_data),
		.frame_done (frame_done),
		.frame_word (frame_word)
	);

	biss_crc6_check u_crc6_check (
		.clk        (clk),
		.BISS_start (BISS_start),
		.bit_valid  (bit_valid),
		.bit_data   (bit_data),
		.frame_done (frame_done),
		.frame_word (frame_word),
		.chk_valid  (chk_valid),
		.chk_word   (chk_word),
		.chk_crc_ok (chk_crc_ok)
	);

	// Consumer side
	biss_result_fifo u_result_fifo (
		.clk        (clk),
		.BISS_start (BISS_start),
		.chk_valid  (chk_valid),
		.chk_word   (chk_word),
		.chk_crc_ok (chk_crc_ok),
		.res_credit (res_credit),
		.fifo_room  (fifo_room),
		.res_valid  (res_valid),
		.res_word   (res_word),
		.res_crc_ok (res_crc_ok)
	);

endmodule

// File: biss_slave_model.sv
`timescale 1ns/10ps
`include "biss_consts.svh"

module biss_slave_model (
	input  logic                clk,
	input  logic                ma,
	input  biss_pkg::scd_word_t tx_word,
	input  logic                corrupt,
	input  logic                silent,
	output logic                slo
);

	biss_pkg::scd_word_t word;
	logic                quiet;
	int                  high_cnt;
	int                  i;

	initial begin
		slo = 1'b1;
		forever begin
			// First MA falling edge opens a frame
			@(negedge ma);
			word  = tx_word;
			quiet = silent;
			if (corrupt)
				word.fld.crc_n[0] = ~word.fld.crc_n[0];
			@(posedge ma);
			@(posedge ma);
			if (quiet) begin
				// Stay high until MA rests, master has given up by then
				high_cnt = 0;
				while (high_cnt < 4 * `BISS_MA_HALF) begin
					@(posedge clk);
					high_cnt = ma ? high_cnt + 1 : 0;
				end
			end else begin
				// Acknowledge for two MA periods
				slo = 1'b0;
				@(posedge ma);
				@(posedge ma);
				slo = 1'b1;
				@(posedge ma);
				// CDS bit
				slo = 1'b0;
				for (i = `BISS_FRAME_BITS - 1; i >= 0; i--) begin
					@(posedge ma);
					slo = word.raw[i];
				end
				// Last bit held past the master's sample point
				repeat (`BISS_MA_HALF + 1) @(negedge clk);
				slo = 1'b0;
				repeat (4 * 2 * `BISS_MA_HALF) @(negedge clk);
				slo = 1'b1;
			end
		end
	end

endmodule

// File: tb_biss_master.sv
`timescale 1ns/10ps
`include "biss_consts.svh"

module tb_biss_master;

	localparam int MA_PERIOD    = 2 * `BISS_MA_HALF;
	// One frame with acknowledge, data and slave timeout, in clk cycles
	localparam int FRAME_CYCLES = 42 * MA_PERIOD;
	localparam int NOACK_CYCLES = (`BISS_ACK_LIMIT + `BISS_IDLE_LIMIT) * MA_PERIOD;
	localparam int NUM_FRAMES   = 17;
	localparam int TIMEOUT_CYCLES = 2 * (NUM_FRAMES * FRAME_CYCLES + NOACK_CYCLES);

	logic                clk;
	logic                BISS_start;
	logic                run;
	logic                slo;
	logic                res_credit = 1'b0;
	logic                ma;
	logic                res_valid;
	biss_pkg::scd_word_t res_word;
	logic                res_crc_ok;
	logic                no_ack;

	// Slave controls
	biss_pkg::scd_word_t tx_word;
	logic                corrupt;
	logic                silent;

	logic                auto_credit;
	int                  credit_owed;
	biss_pkg::scd_word_t exp_words[$];
	logic                exp_oks[$];
	integer              seed;
	int                  errors;
	int                  got_count;
	int                  cycle_cnt;
	int                  tests_passed;
	int                  tests_failed;

	biss_master_top dut_i (
		.clk        (clk),
		.BISS_start (BISS_start),
		.run        (run),
		.slo        (slo),
		.res_credit (res_credit),
		.ma         (ma),
		.res_valid  (res_valid),
		.res_word   (res_word),
		.res_crc_ok (res_crc_ok),
		.no_ack     (no_ack)
	);

	biss_slave_model slave_i (
		.clk     (clk),
		.ma      (ma),
		.tx_word (tx_word),
		.corrupt (corrupt),
		.silent  (silent),
		.slo     (slo)
	);

	always #10 clk = ~clk;

	// ==========================================================================
	// Reference model
	// ==========================================================================

	// Remainder of data * x^6 divided by x^6 + x + 1
	function automatic logic [5:0] crc6_ref(input logic [25:0] data);
		logic [31:0] r;
		int          i;
		r = {data, 6'b0};
		for (i = 31; i >= 6; i--) begin
			if (r[i])
				r[i -: 7] = r[i -: 7] ^ 7'b1000011;
		end
		return r[5:0];
	endfunction

	function automatic biss_pkg::scd_word_t make_word(input logic [31:0] r);
		biss_pkg::scd_word_t w;
		w.fld.position  = r[`BISS_POS_BITS-1:0];
		w.fld.error_n   = r[24];
		w.fld.warning_n = r[25];
		w.fld.crc_n     = ~crc6_ref(w.raw[`BISS_FRAME_BITS-1:`BISS_CRC_BITS]);
		return w;
	endfunction

	task automatic compare_word(input biss_pkg::scd_word_t exp, input biss_pkg::scd_word_t act);
		if (act !== exp) begin
			errors++;
			$display("FAILED at %0t: res_word %h (pos %h), expected %h (pos %h)",
				$time, act.raw, act.fld.position, exp.raw, exp.fld.position);
		end
	endtask

	task automatic compare_flag(input logic exp, input logic act, input string what);
		if (act !== exp) begin
			errors++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
		end
	endtask

	task automatic check_result();
		biss_pkg::scd_word_t exp_w;
		logic                exp_ok;
		got_count++;
		if (exp_words.size() == 0) begin
			errors++;
			$display("Unexpected result at %0t with no frame outstanding", $time);
		end else begin
			exp_w  = exp_words.pop_front();
			exp_ok = exp_oks.pop_front();
			compare_word(exp_w, res_word);
			compare_flag(exp_ok, res_crc_ok, "res_crc_ok");
		end
	endtask

	// Consumer side, results sampled mid-cycle
	always @(negedge clk) begin
		res_credit = 1'b0;
		if (BISS_start && res_valid) begin
			check_result();
			if (auto_credit)
				credit_owed = credit_owed + 1;
		end
		if (credit_owed != 0) begin
			res_credit  = 1'b1;
			credit_owed = credit_owed - 1;
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Simulation timed out waiting for results after %0d cycles", cycle_cnt);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ==========================================================================
	// Helpers
	// ==========================================================================

	// MA high for n cycles in a row means no frame is running
	task automatic wait_ma_rest(input int n);
		int high;
		high = 0;
		while (high < n) begin
			@(negedge clk);
			high = ma ? high + 1 : 0;
		end
	endtask

	task automatic request_frame(input biss_pkg::scd_word_t w, input logic bad_crc,
		input logic quiet);
		biss_pkg::scd_word_t sent;
		sent = w;
		sent.fld.crc_n[0] = w.fld.crc_n[0] ^ bad_crc;
		wait_ma_rest(2 * MA_PERIOD);
		@(negedge clk);
		tx_word = w;
		corrupt = bad_crc;
		silent  = quiet;
		run     = 1'b1;
		@(negedge ma);
		@(negedge clk);
		run = 1'b0;
		if (!quiet) begin
			exp_words.push_back(sent);
			exp_oks.push_back(!bad_crc);
		end
	endtask

	task automatic wait_drain();
		while (exp_words.size() != 0)
			@(posedge clk);
	endtask

	task automatic give_credit();
		@(posedge clk);
		credit_owed = credit_owed + 1;
	endtask

	task automatic end_test(input string name, input int err0);
		if (errors == err0) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err0);
		end
	endtask

	// ==========================================================================
	// Tests
	// ==========================================================================

	task automatic test_reset_state();
		int err0;
		err0 = errors;
		repeat (3) @(negedge clk);
		compare_flag(1'b1, ma, "ma");
		compare_flag(1'b0, res_valid, "res_valid");
		compare_flag(1'b0, no_ack, "no_ack");
		end_test("reset state", err0);
	endtask

	task automatic test_good_frames();
		int          err0;
		logic [31:0] r;
		err0 = errors;
		repeat (8) begin
			r = $random(seed);
			request_frame(make_word(r), 1'b0, 1'b0);
			wait_drain();
		end
		end_test("good frames", err0);
	endtask

	task automatic test_crc_error();
		int          err0;
		logic [31:0] r;
		err0 = errors;
		r = $random(seed);
		request_frame(make_word(r), 1'b1, 1'b0);
		wait_drain();
		// Clean frame right after must pass again
		r = $random(seed);
		request_frame(make_word(r), 1'b0, 1'b0);
		wait_drain();
		end_test("crc error", err0);
	endtask

	task automatic test_no_ack();
		int          err0;
		int          got0;
		int          n;
		logic [31:0] r;
		err0 = errors;
		got0 = got_count;
		r = $random(seed);
		request_frame(make_word(r), 1'b0, 1'b1);
		n = 0;
		while (!no_ack && n < (`BISS_ACK_LIMIT + 2) * MA_PERIOD) begin
			@(negedge clk);
			n++;
		end
		compare_flag(1'b1, no_ack, "no_ack");
		r = $random(seed);
		request_frame(make_word(r), 1'b0, 1'b0);
		wait_drain();
		if (got_count != got0 + 1) begin
			errors++;
			$display("No-ack test saw %0d results instead of one", got_count - got0);
		end
		@(negedge clk);
		compare_flag(1'b0, no_ack, "no_ack");
		end_test("no acknowledge", err0);
	endtask

	task automatic test_back_pressure();
		int          err0;
		int          got0;
		int          target;
		logic        ma_fell;
		logic [31:0] r;
		@(posedge clk);
		err0 = errors;
		got0 = got_count;
		auto_credit = 1'b0;
		repeat (6) begin
			r = $random(seed);
			request_frame(make_word(r), 1'b0, 1'b0);
		end
		// Sixth frame done, buffer now full
		wait_ma_rest(2 * MA_PERIOD);
		if (got_count - got0 != `BISS_CREDIT_INIT) begin
			errors++;
			$display("Back-pressure test saw %0d results without credit return, expected %0d",
				got_count - got0, `BISS_CREDIT_INIT);
		end
		ma_fell = 1'b0;
		@(negedge clk);
		run = 1'b1;
		repeat (200) begin
			@(negedge clk);
			if (!ma)
				ma_fell = 1'b1;
		end
		compare_flag(1'b0, ma_fell, "ma low with full buffer");
		run = 1'b0;
		while (exp_words.size() != 0) begin
			target = got_count + 1;
			give_credit();
			while (got_count < target)
				@(posedge clk);
		end
		auto_credit = 1'b1;
		end_test("back-pressure", err0);
	endtask

	initial begin
		clk          = 1'b0;
		BISS_start   = 1'b0;
		run          = 1'b0;
		tx_word      = '0;
		corrupt      = 1'b0;
		silent       = 1'b0;
		auto_credit  = 1'b1;
		credit_owed  = 0;
		seed         = 32'hb5a6;
		errors       = 0;
		got_count    = 0;
		cycle_cnt    = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (10) @(negedge clk);
		BISS_start = 1'b1;

		test_reset_state();
		test_good_frames();
		test_crc_error();
		test_no_ack();
		test_back_pressure();

		$display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: biss_master.f
+incdir+.
biss_pkg.sv
biss_frame_rx.sv
biss_crc6_check.sv
biss_result_fifo.sv
biss_master_top.sv
biss_slave_model.sv
tb_biss_master.sv

// File: Bender.yml
package:
  name: biss_master

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - biss_pkg.sv
      - biss_frame_rx.sv
      - biss_crc6_check.sv
      - biss_result_fifo.sv
      - biss_master_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - biss_slave_model.sv
      - tb_biss_master.sv
